// ==== src.f ====
+incdir+testbench
source/rv_isa_pkg.sv
source/fetch_pkg.sv
source/fetch_track_if.sv
source/sync_fifo.sv
source/fetch_issuer.sv
source/fetch_collector.sv
source/if_stage.sv
testbench/if_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
# Exit status is the simulator's, nonzero on any failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
  -f src.f \
  --top-module if_stage_tb \
  -Mdir obj_dir \
  -o if_stage_sim

./obj_dir/if_stage_sim

// ==== testbench/if_stage_checks.svh ====
// Compare tasks and the common failure path of if_stage_tb

// Report the problem, print the verdict and stop
task automatic stop_run(input string msg);
  $display("%s", msg);
  $display("Result: FAILED");
  $fatal(1, "run stopped at the first error");
endtask

// Single-bit handshake and valid flags
task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    stop_run($sformatf("** Error at %0t: %s is %b, expected %b", $time, name, got, exp));
  end
endtask

// Memory read address
task automatic check_addr(input string name, input xaddr_t got, input xaddr_t exp);
  if (got !== exp) begin
    stop_run($sformatf("** Error at %0t: %s is %h, expected %h", $time, name, got, exp));
  end
endtask

// Fetch seen by decode, instruction with its PC and sequential PC
task automatic check_fetch(
  input string  name,
  input instr_t got_instr,
  input instr_t exp_instr,
  input xaddr_t got_pc,
  input xaddr_t exp_pc,
  input xaddr_t got_plus4,
  input xaddr_t exp_plus4
);
  if (got_instr !== exp_instr) begin
    stop_run($sformatf("** Error at %0t: %s instr is %h, expected %h",
                       $time, name, got_instr, exp_instr));
  end
  if (got_pc !== exp_pc) begin
    stop_run($sformatf("** Error at %0t: %s pc_out is %h, expected %h",
                       $time, name, got_pc, exp_pc));
  end
  if (got_plus4 !== exp_plus4) begin
    stop_run($sformatf("** Error at %0t: %s pc_plus4 is %h, expected %h",
                       $time, name, got_plus4, exp_plus4));
  end
endtask

// Whole metadata struct in one compare
task automatic check_meta(input string name, input fetch_meta_t got, input fetch_meta_t exp);
  if (got !== exp) begin
    stop_run($sformatf("** Error at %0t: %s meta_out is %h, expected %h",
                       $time, name, got, exp));
  end
endtask

// ==== testbench/if_stage_tb.sv ====
`timescale 1ns/100ps

module if_stage_tb
  import rv_isa_pkg::*;
  import fetch_pkg::*;
();

  // ======================================================================
  // Run setup
  // ======================================================================

  localparam int          QUEUE_AW     = QUEUE_AW_DEFAULT;
  localparam int          HALF_DEPTH   = (1 << QUEUE_AW) / 2;
  localparam int          RESET_CYCLES = 10;
  localparam int          TEST_CYCLES  = 4000;
  // All cycles at 20 ns plus room for the final drain
  localparam int          WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + 200) * 20;
  // Memory word is its address XOR this
  localparam logic [31:0] MEM_XOR      = 32'h5a3c_96e1;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  logic        clk, rst_n, flush;
  logic        s_valid, s_ready, imem_arvalid, imem_rvalid, m_valid, m_ready;
  xaddr_t      pc, imem_araddr, pc_out, pc_plus4;
  instr_t      imem_rdata, instr;
  fetch_meta_t meta, meta_out;

  // Model state
  logic [31:0] lfsr;
  int          cyc, last_due, n_accepted, n_xfer, n_discard;
  logic        acc_prev, flush_prev, hold_pending;
  instr_t      held_instr;
  xaddr_t      held_pc, held_plus4;
  fetch_meta_t held_meta;
  // Reads in flight with the cycle each one answers
  xaddr_t      mem_addr_q[$];
  int          mem_due_q[$];
  // Accepted requests not yet delivered
  xaddr_t      ref_pc_q[$];
  fetch_meta_t ref_meta_q[$];

  `include "if_stage_checks.svh"

  if_stage #(.QUEUE_AW (QUEUE_AW)) dut0 (.*);

  always #10 clk = ~clk;

  // ======================================================================
  // Random source
  // ======================================================================

  // One Galois step per bit
  function automatic logic rand_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) begin
      lfsr = lfsr ^ LFSR_TAPS;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic fetch_meta_t random_meta();
    fetch_meta_t m;
    m.btb_hit        = rand_bit();
    m.btb_pred_taken = rand_bit();
    m.btb_target     = rand_bits(32);
    m.btb_is_return  = rand_bit();
    m.ras_valid      = rand_bit();
    m.ras_target     = rand_bits(32);
    return m;
  endfunction

  // ======================================================================
  // Stimulus and memory model, on the rising edge
  // ======================================================================

  task automatic drive_inputs(input logic draining);
    logic flush_now;
    cyc++;
    rst_n <= (cyc >= RESET_CYCLES);
    // Head read answers once due
    if (mem_due_q.size() != 0 && mem_due_q[0] == cyc) begin
      imem_rvalid <= 1'b1;
      imem_rdata  <= mem_addr_q[0] ^ MEM_XOR;
      void'(mem_due_q.pop_front());
      void'(mem_addr_q.pop_front());
    end else begin
      imem_rvalid <= 1'b0;
      imem_rdata  <= rand_bits(32);
    end
    // Flush only with nothing due after this cycle
    flush_now = 1'b0;
    if (!draining && !flush && cyc > RESET_CYCLES + 1 && mem_due_q.size() == 0) begin
      flush_now = (rand_bits(4) == 0);
    end
    flush <= flush_now;
    if (flush_now || flush || cyc <= RESET_CYCLES) begin
      s_valid <= 1'b0;
    end else if (!(s_valid && !acc_prev)) begin
      // Pending request holds, otherwise pick a new one
      s_valid <= !draining && (rand_bits(2) != 0);
      pc      <= rand_bits(30) << 2;
      meta    <= random_meta();
    end
    m_ready <= draining || (rand_bits(2) != 0);
  endtask

  // ======================================================================
  // Checks and reference model, mid-cycle
  // ======================================================================

  task automatic observe_cycle();
    logic   exp_ready;
    logic   accepted;
    int     due;
    xaddr_t exp_pc;
    // Reads in flight, the one answered now included
    exp_ready = m_ready && (mem_due_q.size() + int'(imem_rvalid) < HALF_DEPTH);
    accepted  = s_valid && exp_ready;
    if (cyc <= RESET_CYCLES) begin
      check_flag("imem_arvalid around reset", imem_arvalid, 1'b0);
      check_flag("m_valid around reset", m_valid, 1'b0);
    end
    if (!m_ready) begin
      check_flag("s_ready with m_ready low", s_ready, 1'b0);
    end
    check_flag("s_ready", s_ready, exp_ready);
    check_flag("imem_arvalid", imem_arvalid, accepted);
    if (accepted) begin
      check_addr("imem_araddr", imem_araddr, pc);
    end
    // Stalled output stays put
    if (hold_pending) begin
      check_flag("m_valid while stalled", m_valid, 1'b1);
      check_fetch("stalled output", instr, held_instr, pc_out, held_pc, pc_plus4, held_plus4);
      check_meta("stalled output", meta_out, held_meta);
    end
    if (flush_prev) begin
      check_flag("m_valid after flush", m_valid, 1'b0);
    end
    if (m_valid && ref_pc_q.size() == 0) begin
      stop_run("Decode port shows a fetch that was never accepted or was flushed");
    end
    if (m_valid && m_ready) begin
      exp_pc = ref_pc_q.pop_front();
      check_fetch("decode transfer", instr, exp_pc ^ MEM_XOR, pc_out, exp_pc,
                  pc_plus4, exp_pc + xaddr_t'(INSTR_STEP));
      check_meta("decode transfer", meta_out, ref_meta_q.pop_front());
      n_xfer++;
    end
    if (accepted) begin
      // Latency 1 to 3, kept in order
      due = cyc + 1 + int'(rand_bit()) + int'(rand_bit());
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      mem_addr_q.push_back(pc);
      mem_due_q.push_back(due);
      ref_pc_q.push_back(pc);
      ref_meta_q.push_back(meta);
      n_accepted++;
    end
    if (flush) begin
      n_discard += ref_pc_q.size();
      ref_pc_q.delete();
      ref_meta_q.delete();
    end
    hold_pending = m_valid && !m_ready && !flush;
    held_instr   = instr;
    held_pc      = pc_out;
    held_plus4   = pc_plus4;
    held_meta    = meta_out;
    flush_prev   = flush;
    acc_prev     = accepted;
  endtask

  always @(posedge clk) begin
    drive_inputs(cyc >= RESET_CYCLES + TEST_CYCLES);
  end

  always @(negedge clk) begin
    observe_cycle();
  end

  // ======================================================================
  // Run control
  // ======================================================================

  initial begin
    lfsr         = 32'hf2bff327;
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    s_valid      = 1'b0;
    pc           = '0;
    meta         = '0;
    imem_rvalid  = 1'b0;
    imem_rdata   = '0;
    m_ready      = 1'b0;
    cyc          = 0;
    last_due     = 0;
    n_accepted   = 0;
    n_xfer       = 0;
    n_discard    = 0;
    acc_prev     = 1'b0;
    flush_prev   = 1'b0;
    hold_pending = 1'b0;
    // Run the test cycles, then drain until no request, read or output is left
    do begin
      @(negedge clk);
      #1;
    end while (cyc < RESET_CYCLES + TEST_CYCLES || s_valid || mem_due_q.size() != 0 ||
               imem_rvalid || m_valid);
    if (n_xfer != n_accepted - n_discard || ref_pc_q.size() != 0) begin
      stop_run($sformatf("Count mismatch: %0d accepted, %0d flushed, %0d delivered",
                         n_accepted, n_discard, n_xfer));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    stop_run($sformatf("Timeout: run did not finish within %0d ns", WATCHDOG_NS));
  end

endmodule

// ==== source/if_stage.sv ====
`timescale 1ns/100ps

// Instruction fetch stage
// PC stage requests go to memory, responses come back in order and
// leave toward decode with their PC and prediction metadata
module if_stage
  import rv_isa_pkg::*;
  import fetch_pkg::*;
#(
  // Queue depth is 2**QUEUE_AW, reads in flight at most half of it
  parameter int QUEUE_AW = QUEUE_AW_DEFAULT
) (
  input  logic        clk,
  input  logic        rst_n,

  // ======================================================================
  // Control
  // ======================================================================

  // Redirect from later stages, drops everything in flight
  input  logic        flush,

  // ======================================================================
  // Upstream from the PC stage
  // ======================================================================

  input  logic        s_valid,
  output logic        s_ready,
  input  xaddr_t      pc,
  input  fetch_meta_t meta,

  // ======================================================================
  // Instruction memory
  // ======================================================================

  // Read request, no ready, always accepted
  output logic        imem_arvalid,
  output xaddr_t      imem_araddr,

  // In-order response, one per read
  input  logic        imem_rvalid,
  input  instr_t      imem_rdata,

  // ======================================================================
  // Downstream to decode
  // ======================================================================

  output logic        m_valid,
  input  logic        m_ready,
  output instr_t      instr,
  output xaddr_t      pc_out,
  output xaddr_t      pc_plus4,
  output fetch_meta_t meta_out
);

  // Bookkeeping between the two halves
  fetch_track_if track0 ();

  // Request side and address tracking
  fetch_issuer #(
    .QUEUE_AW (QUEUE_AW)
  ) issuer0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .s_valid      (s_valid),
    .s_ready      (s_ready),
    .pc           (pc),
    .meta         (meta),
    .m_ready      (m_ready),
    .imem_arvalid (imem_arvalid),
    .imem_araddr  (imem_araddr),
    .imem_rvalid  (imem_rvalid),
    .track        (track0.issuer)
  );

  // Response side and decode output
  fetch_collector #(
    .QUEUE_AW (QUEUE_AW)
  ) collector0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_rdata (imem_rdata),
    .track      (track0.collector),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .instr      (instr),
    .pc_out     (pc_out),
    .pc_plus4   (pc_plus4),
    .meta_out   (meta_out)
  );

endmodule

// ==== source/fetch_collector.sv ====
`timescale 1ns/100ps

// Back half of the fetch stage
// Holds taken responses and their metadata until decode accepts them
module fetch_collector
  import rv_isa_pkg::*;
  import fetch_pkg::*;
#(
  parameter int QUEUE_AW = QUEUE_AW_DEFAULT
) (
  input  logic        clk,
  input  logic        rst_n,

  // Returned instruction word, valid with track.take
  input  instr_t      imem_rdata,

  fetch_track_if.collector track,

  // Decode side
  output logic        m_valid,
  input  logic        m_ready,
  output instr_t      instr,
  output xaddr_t      pc_out,
  output xaddr_t      pc_plus4,
  output fetch_meta_t meta_out
);

  localparam int RESP_W = XLEN + ILEN;
  localparam int META_W = $bits(fetch_meta_t);

  logic pop;
  logic resp_empty;

  // One decode transfer retires one entry from both queues
  assign pop = m_valid && m_ready;

  // ======================================================================
  // Response queue holding PC and instruction together
  // ======================================================================

  logic [RESP_W-1:0] resp_wdata;
  logic [RESP_W-1:0] resp_rdata;

  assign resp_wdata = {track.take_pc, imem_rdata};

  sync_fifo #(
    .WIDTH    (RESP_W),
    .QUEUE_AW (QUEUE_AW)
  ) resp_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr         (track.clr),
    .w_inc       (track.take),
    .w_data      (resp_wdata),
    .r_inc       (pop),
    .r_data      (resp_rdata),
    .r_empty     (resp_empty),
    .w_half_full ()
  );

  // ======================================================================
  // Metadata queue, filled at request time
  // ======================================================================

  // Always at least as full as the response queue, so its
  // head belongs to the response at the head
  logic [META_W-1:0] meta_rdata;

  sync_fifo #(
    .WIDTH    (META_W),
    .QUEUE_AW (QUEUE_AW)
  ) meta_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr         (track.clr),
    .w_inc       (track.push),
    .w_data      (track.push_meta),
    .r_inc       (pop),
    .r_data      (meta_rdata),
    .r_empty     (),
    .w_half_full ()
  );

  // ======================================================================
  // Decode outputs
  // ======================================================================

  // A response entry exists only after its instruction arrived
  assign m_valid = !resp_empty;

  assign {pc_out, instr} = resp_rdata;
  assign meta_out        = fetch_meta_t'(meta_rdata);

  // Sequential successor for the link register and fall-through path
  assign pc_plus4 = pc_out + xaddr_t'(INSTR_STEP);

endmodule

// ==== source/fetch_issuer.sv ====
`timescale 1ns/100ps

// Front half of the fetch stage
// Starts memory reads and pairs each response with its address
module fetch_issuer
  import rv_isa_pkg::*;
  import fetch_pkg::*;
#(
  parameter int QUEUE_AW = QUEUE_AW_DEFAULT
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush,

  // Requests from the PC stage
  input  logic        s_valid,
  output logic        s_ready,
  input  xaddr_t      pc,
  input  fetch_meta_t meta,

  // Decode readiness, used as back-pressure
  input  logic        m_ready,

  // Instruction memory read side
  output logic        imem_arvalid,
  output xaddr_t      imem_araddr,
  input  logic        imem_rvalid,

  fetch_track_if.issuer track
);

  // ======================================================================
  // Flush and its extension
  // ======================================================================

  logic flush_ext;
  logic clr;

  // The read issued just before a redirect can still answer one cycle
  // after the flush, so the clear is stretched by a cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush_ext <= 1'b0;
    end else begin
      flush_ext <= flush;
    end
  end

  assign clr = flush || flush_ext;

  // ======================================================================
  // Request acceptance
  // ======================================================================

  logic accept;
  logic addr_empty;
  logic addr_half_full;

  // Stall when decode stalls or too many reads are in flight
  assign s_ready = m_ready && !addr_half_full;
  assign accept  = s_valid && s_ready;

  // Read goes out in the same cycle as the upstream transfer
  assign imem_arvalid = accept;
  assign imem_araddr  = pc;

  // ======================================================================
  // Outstanding addresses in issue order
  // ======================================================================

  logic take;

  // A response counts only with a recorded address and no clear active
  assign take = imem_rvalid && !clr && !addr_empty;

  sync_fifo #(
    .WIDTH    ($bits(xaddr_t)),
    .QUEUE_AW (QUEUE_AW)
  ) addr_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr         (clr),
    .w_inc       (accept),
    .w_data      (pc),
    .r_inc       (take),
    .r_data      (track.take_pc),
    .r_empty     (addr_empty),
    .w_half_full (addr_half_full)
  );

  // ======================================================================
  // Collector bookkeeping
  // ======================================================================

  assign track.clr       = clr;
  // Metadata enters only outside a clear, matching the address queue
  assign track.push      = accept && !clr;
  assign track.push_meta = meta;
  assign track.take      = take;

endmodule

// ==== source/sync_fifo.sv ====
`timescale 1ns/100ps

// Circular buffer with occupancy count and a one-cycle clear
module sync_fifo
  import fetch_pkg::*;
#(
  parameter int WIDTH    = 1,
  parameter int QUEUE_AW = QUEUE_AW_DEFAULT
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clr,
  input  logic             w_inc,
  input  logic [WIDTH-1:0] w_data,
  input  logic             r_inc,
  output logic [WIDTH-1:0] r_data,
  output logic             r_empty,
  output logic             w_half_full
);

  localparam int DEPTH = 1 << QUEUE_AW;

  // Count thresholds sized to the counter
  localparam logic [QUEUE_AW:0] FULL_COUNT = (QUEUE_AW + 1)'(DEPTH);
  localparam logic [QUEUE_AW:0] HALF_COUNT = (QUEUE_AW + 1)'(DEPTH / 2);

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [QUEUE_AW-1:0] wr_ptr;
  logic [QUEUE_AW-1:0] rd_ptr;
  logic [QUEUE_AW:0]   count;
  logic                do_wr;
  logic                do_rd;

  // Pop only real entries
  assign do_rd = r_inc && !r_empty;

  // A full queue still takes a write when the head leaves in the same cycle
  assign do_wr = w_inc && ((count != FULL_COUNT) || do_rd);

  assign r_empty     = (count == '0);
  assign w_half_full = (count >= HALF_COUNT);

  // Head word is valid whenever the queue is not empty
  assign r_data = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr && !clr) begin
      mem[wr_ptr] <= w_data;
    end
  end

  // Pointers and count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clr) begin
      // Clear wins over any push or pop in the same cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== source/fetch_track_if.sv ====
`timescale 1ns/100ps

// Bookkeeping link from the issuer to the collector
// The issuer decides everything, the collector only follows
interface fetch_track_if
  import rv_isa_pkg::*;
  import fetch_pkg::*;
();

  // Queue clear, high during flush and during its extension
  logic        clr;

  // A request was accepted this cycle
  logic        push;

  // Metadata of the accepted request
  fetch_meta_t push_meta;

  // A memory response is taken into the collector this cycle
  logic        take;

  // PC of the response being taken, in issue order
  xaddr_t      take_pc;

  // Issuer side drives every signal
  modport issuer (
    output clr,
    output push,
    output push_meta,
    output take,
    output take_pc
  );

  // Collector side only listens
  modport collector (
    input clr,
    input push,
    input push_meta,
    input take,
    input take_pc
  );

endinterface

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

  import rv_isa_pkg::*;

  // ======================================================================
  // Fetch pipeline structures
  // ======================================================================

  // Prediction metadata produced by the PC stage
  // Travels beside each fetch and reaches decode with its instruction
  typedef struct packed {
    // BTB lookup hit for this PC
    logic   btb_hit;
    // BTB predicted the branch as taken
    logic   btb_pred_taken;
    // Predicted target from the BTB
    xaddr_t btb_target;
    // BTB entry marks a return
    logic   btb_is_return;
    // RAS had an entry to offer
    logic   ras_valid;
    // Return address popped from the RAS
    xaddr_t ras_target;
  } fetch_meta_t;

  // Default queue address width
  // Two bits give four entries, so two reads can be outstanding
  parameter int QUEUE_AW_DEFAULT = 2;

endpackage

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // ======================================================================
  // Base ISA facts used by the fetch stage
  // ======================================================================

  // Register and address width
  parameter int XLEN = 32;

  // Instruction word width for the base encoding without compressed forms
  parameter int ILEN = 32;

  // Byte distance from one instruction to the next sequential one
  parameter int INSTR_STEP = 4;

  // PC or branch target word
  typedef logic [XLEN-1:0] xaddr_t;

  // Raw instruction word as returned by instruction memory
  typedef logic [ILEN-1:0] instr_t;

endpackage
